/* src/mmc5_pkg.sv */
// Shared MMC5 constants and the PRG selector type, referenced by scoped names from the RTL
`default_nettype none

package mmc5_pkg;

	// Upper address bits of the CPU-side windows
	localparam logic [5:0] reg_base_hi   = 6'b010100; // $5000-$53FF
	localparam logic [5:0] exram_base_hi = 6'b010111; // $5C00-$5FFF

	// Register offsets inside the $5000 window
	localparam logic [9:0] reg_prg_mode      = 10'h100;
	localparam logic [9:0] reg_chr_mode      = 10'h101;
	localparam logic [9:0] reg_protect_1     = 10'h102; // Key 2'b10 unlocks
	localparam logic [9:0] reg_protect_2     = 10'h103; // Key 2'b01 unlocks
	localparam logic [9:0] reg_exram_mode    = 10'h104;
	localparam logic [9:0] reg_mirroring     = 10'h105;
	localparam logic [9:0] reg_prg_ram_bank  = 10'h113;
	localparam logic [9:0] reg_prg_bank_0    = 10'h114;
	localparam logic [9:0] reg_prg_bank_1    = 10'h115;
	localparam logic [9:0] reg_prg_bank_2    = 10'h116;
	localparam logic [9:0] reg_prg_bank_3    = 10'h117;
	localparam logic [9:0] reg_chr_bank_base = 10'h120; // $5120-$512B, twelve banks
	localparam logic [9:0] reg_chr_upper     = 10'h130;
	localparam logic [9:0] reg_irq_scanline  = 10'h203;
	localparam logic [9:0] reg_irq_status    = 10'h204; // Enable on write, status on read
	localparam logic [9:0] reg_mult_1        = 10'h205;
	localparam logic [9:0] reg_mult_2        = 10'h206;

	localparam int prg_aw         = 22; // PRG address out
	localparam int chr_aw         = 22; // CHR address out
	localparam int chr_bank_w     = 10; // 2 upper bits plus written byte
	localparam int chr_bank_count = 12;
	localparam int prg_page_w     = 13; // 8 kB page offset

	localparam logic [5:0] prg_ram_page = 6'h3C; // Save RAM sits high in PRG space
	localparam logic [1:0] chr_space    = 2'b10;
	localparam int         irq_last_line = 240;  // Compare must stay below

	// One selector word, decoded by its top bit
	typedef union packed {
		struct packed {
			logic       is_rom;
			logic [6:0] bank;
		} rom;
		struct packed {
			logic       is_rom;
			logic [3:0] unused;
			logic [2:0] bank;   // 64 kB of RAM at most
		} ram;
	} prg_sel_u;

endpackage

`default_nettype wire

/* src/mmc5_cfg_if.sv */
// Configuration register bundle, written by the register file and read by the mapping blocks
`timescale 1ns/1ps
`default_nettype none

interface mmc5_cfg_if;

	logic [1:0] prg_mode;
	logic [1:0] chr_mode;
	logic       prg_protect_1;  // Key matched on $5102
	logic       prg_protect_2;  // Key matched on $5103
	logic [1:0] exram_mode;
	logic [7:0] mirroring;      // Two bits per nametable
	logic [2:0] prg_ram_bank;
	logic [7:0] prg_bank_0;     // Bit 7 selects ROM
	logic [7:0] prg_bank_1;
	logic [7:0] prg_bank_2;
	logic [6:0] prg_bank_3;     // Always ROM
	logic [mmc5_pkg::chr_bank_count-1:0][mmc5_pkg::chr_bank_w-1:0] chr_bank;
	logic       chr_last;       // Set written last, 1 for $5128-$512B
	logic [7:0] irq_scanline;
	logic       irq_enable;
	logic [7:0] mult_1;
	logic [7:0] mult_2;

	modport regs (
		output prg_mode, chr_mode, prg_protect_1, prg_protect_2, exram_mode, mirroring,
		output prg_ram_bank, prg_bank_0, prg_bank_1, prg_bank_2, prg_bank_3,
		output chr_bank, chr_last, irq_scanline, irq_enable, mult_1, mult_2
	);

	modport prg (
		input prg_mode, prg_protect_1, prg_protect_2, prg_ram_bank,
		input prg_bank_0, prg_bank_1, prg_bank_2, prg_bank_3
	);

	modport chr (input chr_mode, chr_bank, chr_last, mirroring);

	modport irq (input irq_scanline, irq_enable);

	modport cpu (input exram_mode, mult_1, mult_2);

endinterface

`default_nettype wire

/* src/mmc5_regs.sv */
// Register file for CPU writes to $5100-$5206, drives the configuration bundle
`timescale 1ns/1ps
`default_nettype none

module mmc5_regs (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        ce,           // CPU cycle strobe
	input  logic        prg_write,
	input  logic [15:0] prg_ain,
	input  logic [7:0]  prg_din,
	input  logic        ppu_sprite16, // 8x16 sprites on
	mmc5_cfg_if.regs    cfg
);

	logic [9:0] off;
	logic       wr;
	logic [3:0] chr_idx;
	logic       chr_hit;
	logic [1:0] chr_upper;    // $5130, prepended to CHR bank writes
	logic       old_sprite16;

	assign off     = prg_ain[9:0];
	assign wr      = ce && prg_write && (prg_ain[15:10] == mmc5_pkg::reg_base_hi);
	assign chr_idx = off[3:0];
	// $5120-$512B only
	assign chr_hit = (off[9:4] == mmc5_pkg::reg_chr_bank_base[9:4]) &&
		(chr_idx < mmc5_pkg::chr_bank_count);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg.prg_mode      <= 2'd3;  // 8 kB banks, last bank fixed
			cfg.chr_mode      <= '0;
			cfg.prg_protect_1 <= 1'b0;
			cfg.prg_protect_2 <= 1'b0;
			cfg.exram_mode    <= '0;
			cfg.mirroring     <= '0;
			cfg.prg_ram_bank  <= '0;
			cfg.prg_bank_0    <= '0;
			cfg.prg_bank_1    <= '0;
			cfg.prg_bank_2    <= '0;
			cfg.prg_bank_3    <= 7'h7F; // Reset vector lands in the last bank
			cfg.chr_bank      <= '0;
			cfg.chr_last      <= 1'b0;
			cfg.irq_scanline  <= '0;
			cfg.irq_enable    <= 1'b0;
			cfg.mult_1        <= '0;
			cfg.mult_2        <= '0;
			chr_upper         <= '0;
			old_sprite16      <= 1'b0;
		end else if (ce) begin
			if (wr) begin
				case (off)
					mmc5_pkg::reg_prg_mode:     cfg.prg_mode <= prg_din[1:0];
					mmc5_pkg::reg_chr_mode:     cfg.chr_mode <= prg_din[1:0];
					mmc5_pkg::reg_protect_1:    cfg.prg_protect_1 <= (prg_din[1:0] == 2'b10);
					mmc5_pkg::reg_protect_2:    cfg.prg_protect_2 <= (prg_din[1:0] == 2'b01);
					mmc5_pkg::reg_exram_mode:   cfg.exram_mode <= prg_din[1:0];
					mmc5_pkg::reg_mirroring:    cfg.mirroring <= prg_din;
					mmc5_pkg::reg_prg_ram_bank: cfg.prg_ram_bank <= prg_din[2:0];
					mmc5_pkg::reg_prg_bank_0:   cfg.prg_bank_0 <= prg_din;
					mmc5_pkg::reg_prg_bank_1:   cfg.prg_bank_1 <= prg_din;
					mmc5_pkg::reg_prg_bank_2:   cfg.prg_bank_2 <= prg_din;
					mmc5_pkg::reg_prg_bank_3:   cfg.prg_bank_3 <= prg_din[6:0];
					mmc5_pkg::reg_chr_upper:    chr_upper <= prg_din[1:0];
					mmc5_pkg::reg_irq_scanline: cfg.irq_scanline <= prg_din;
					mmc5_pkg::reg_irq_status:   cfg.irq_enable <= prg_din[7];
					mmc5_pkg::reg_mult_1:       cfg.mult_1 <= prg_din;
					mmc5_pkg::reg_mult_2:       cfg.mult_2 <= prg_din;
					default: begin
						if (chr_hit)
							cfg.chr_bank[chr_idx] <= {chr_upper, prg_din};
					end
				endcase

				// Sprite set with 8x16 on, otherwise back to set 0
				if (chr_hit)
					cfg.chr_last <= off[3] & ppu_sprite16;
			end

			// Switching to 8x8 sprites returns to the sprite set, overrides the write above
			old_sprite16 <= ppu_sprite16;
			if (old_sprite16 && !ppu_sprite16)
				cfg.chr_last <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* src/mmc5_prg_map.sv */
// CPU address to PRG ROM/RAM address translation and access permission
`timescale 1ns/1ps
`default_nettype none

module mmc5_prg_map (
	input  logic [15:0]                  prg_ain,
	input  logic                         prg_write,
	mmc5_cfg_if.prg                      cfg,
	output logic [mmc5_pkg::prg_aw-1:0]  prg_aout,
	output logic                         prg_allow  // Access may proceed
);

	mmc5_pkg::prg_sel_u sel;
	logic [mmc5_pkg::prg_page_w-1:0] page;
	logic ram_we;

	assign page = prg_ain[mmc5_pkg::prg_page_w-1:0];

	always_comb begin
		// $6000-$7FFF and anything unmapped below it
		sel.ram.is_rom = 1'b0;
		sel.ram.unused = '0;
		sel.ram.bank   = cfg.prg_ram_bank;
		if (prg_ain[15]) begin
			case (cfg.prg_mode)
				2'd0: sel = {1'b1, cfg.prg_bank_3[6:2], prg_ain[14:13]};  // 32 kB
				2'd1: begin
					if (!prg_ain[14])
						sel = {cfg.prg_bank_1[7:1], prg_ain[13]};         // 16 kB, may be RAM
					else
						sel = {1'b1, cfg.prg_bank_3[6:1], prg_ain[13]};   // 16 kB fixed ROM
				end
				2'd2: begin
					case (prg_ain[14:13])
						2'b00, 2'b01: sel = {cfg.prg_bank_1[7:1], prg_ain[13]};
						2'b10:        sel = cfg.prg_bank_2;              // 8 kB
						default:      sel = {1'b1, cfg.prg_bank_3};
					endcase
				end
				default: begin
					case (prg_ain[14:13])
						2'b00:   sel = cfg.prg_bank_0;
						2'b01:   sel = cfg.prg_bank_1;
						2'b10:   sel = cfg.prg_bank_2;
						default: sel = {1'b1, cfg.prg_bank_3};
					endcase
				end
			endcase
		end
	end

	// Read back through the view that the top bit picks
	assign prg_aout = sel.rom.is_rom ? {2'b00, sel.rom.bank, page}
		: {mmc5_pkg::prg_ram_page, sel.ram.bank, page};

	assign ram_we    = cfg.prg_protect_1 && cfg.prg_protect_2; // Both keys written
	assign prg_allow = (prg_ain >= 16'h6000) && (!prg_write || (!sel.ram.is_rom && ram_we));

endmodule

`default_nettype wire

/* src/mmc5_chr_map.sv */
// PPU address to CHR address translation, plus nametable mirroring outputs
`timescale 1ns/1ps
`default_nettype none

module mmc5_chr_map (
	input  logic [13:0]                 chr_ain,
	input  logic                        ppu_in_frame,
	input  logic                        ppu_sprite16,
	input  logic [8:0]                  ppu_cycle,
	mmc5_cfg_if.chr                     cfg,
	output logic [mmc5_pkg::chr_aw-1:0] chr_aout,
	output logic                        vram_a10,  // Internal VRAM A10
	output logic                        vram_ce    // Route to internal VRAM
);

	logic                            is_bg_fetch;
	logic                            chrset;    // 0 sprite set, 1 background set
	logic [3:0]                      idx;       // Bank register picked
	logic [mmc5_pkg::chr_bank_w-1:0] bank;
	logic [mmc5_pkg::chr_bank_w-1:0] chrsel;   // 1 kB page number
	logic [1:0]                      mirrbits;

	// Sprite pattern fetches happen in cycles 256-319
	assign is_bg_fetch = !((ppu_cycle >= 9'd256) && (ppu_cycle < 9'd320));
	// Split sets only matter with 8x16 sprites while rendering
	assign chrset = (ppu_sprite16 && ppu_in_frame) ? is_bg_fetch : cfg.chr_last;

	always_comb begin
		case (cfg.chr_mode)
			2'd0: idx = chrset ? 4'd11 : 4'd7;                        // 8 kB
			2'd1: idx = chrset ? 4'd11 : (chr_ain[12] ? 4'd7 : 4'd3); // 4 kB
			2'd2: begin                                               // 2 kB
				if (chrset)
					idx = chr_ain[11] ? 4'd11 : 4'd9;
				else
					idx = {1'b0, chr_ain[12:11], 1'b1};
			end
			default: begin                                            // 1 kB
				if (chrset)
					idx = {2'b10, chr_ain[11:10]};   // Background set repeats
				else
					idx = {1'b0, chr_ain[12:10]};
			end
		endcase
	end

	assign bank = cfg.chr_bank[idx];

	always_comb begin
		case (cfg.chr_mode)
			2'd0:    chrsel = {bank[6:0], chr_ain[12:10]};
			2'd1:    chrsel = {bank[7:0], chr_ain[11:10]};
			2'd2:    chrsel = {bank[8:0], chr_ain[10]};
			default: chrsel = bank;
		endcase
	end

	assign chr_aout = {mmc5_pkg::chr_space, chrsel, chr_ain[9:0]};

	// 00 NTA, 01 NTB, 1x not internal VRAM
	assign mirrbits = cfg.mirroring[{chr_ain[11:10], 1'b0} +: 2];
	assign vram_a10 = mirrbits[0];
	assign vram_ce  = chr_ain[13] && !mirrbits[1];

endmodule

`default_nettype wire

/* src/mmc5_scanline_irq.sv */
// Scanline compare IRQ with its pending flag, cleared by the $5204 status read
`timescale 1ns/1ps
`default_nettype none

module mmc5_scanline_irq (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ce,
	input  logic       ppu_ce,
	input  logic       ppu_in_frame,
	input  logic [8:0] ppu_scanline,
	input  logic       status_read,  // CPU read of $5204
	mmc5_cfg_if.irq    cfg,
	output logic       irq_pending,
	output logic       irq
);

	logic last_line_bit;  // Bit 0 of the previous scanline
	logic irq_trig;

	// Zero and lines from 240 up never fire
	assign irq_trig = (cfg.irq_scanline != 8'd0) &&
		(int'(cfg.irq_scanline) < mmc5_pkg::irq_last_line) &&
		(ppu_scanline == {1'b0, cfg.irq_scanline});

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_line_bit <= 1'b0;
			irq_pending   <= 1'b0;
		end else if (ce || ppu_ce) begin
			last_line_bit <= ppu_scanline[0];
			if (status_read || !ppu_in_frame)
				irq_pending <= 1'b0;   // Clear wins over set
			else if ((ppu_scanline[0] != last_line_bit) && irq_trig)
				irq_pending <= 1'b1;   // New line matched
		end
	end

	assign irq = irq_pending && cfg.irq_enable;

endmodule

`default_nettype wire

/* src/mmc5_cpu_port.sv */
// Expansion RAM at $5C00, the 8x8 multiplier and the CPU read-back mux
`timescale 1ns/1ps
`default_nettype none

module mmc5_cpu_port #(
	parameter int exram_aw = 10  // Smaller RAM aliases inside the 1 kB window
) (
	input  logic        clk,
	input  logic        ce,
	input  logic        prg_read,
	input  logic        prg_write,
	input  logic [15:0] prg_ain,
	input  logic [7:0]  prg_din,
	input  logic        ppu_in_frame,
	input  logic        irq_pending,
	mmc5_cfg_if.cpu     cfg,
	output logic        status_read,  // Clears the pending IRQ
	output logic [7:0]  prg_dout
);

	logic [7:0]          exram [2**exram_aw];
	logic [7:0]          exram_q;   // Registered read
	logic [exram_aw-1:0] exram_a;
	logic                in_exram;
	logic [15:0]         product;

	assign exram_a  = prg_ain[exram_aw-1:0];
	assign in_exram = (prg_ain[15:10] == mmc5_pkg::exram_base_hi);
	assign product  = cfg.mult_1 * cfg.mult_2;

	// Mode 3 is read-only, modes 0 and 1 store zero outside rendering
	always_ff @(posedge clk) begin
		if (ce && prg_write && in_exram && (cfg.exram_mode != 2'd3))
			exram[exram_a] <= (cfg.exram_mode[1] || ppu_in_frame) ? prg_din : 8'h00;
		exram_q <= exram[exram_a];  // Valid one cycle after the address
	end

	assign status_read = ce && prg_read &&
		(prg_ain == {mmc5_pkg::reg_base_hi, mmc5_pkg::reg_irq_status});

	always_comb begin
		if (in_exram && cfg.exram_mode[1])
			prg_dout = exram_q;
		else if (prg_ain == {mmc5_pkg::reg_base_hi, mmc5_pkg::reg_irq_status})
			prg_dout = {irq_pending, ppu_in_frame, 6'b111111};
		else if (prg_ain == {mmc5_pkg::reg_base_hi, mmc5_pkg::reg_mult_1})
			prg_dout = product[7:0];
		else if (prg_ain == {mmc5_pkg::reg_base_hi, mmc5_pkg::reg_mult_2})
			prg_dout = product[15:8];
		else
			prg_dout = 8'hFF;  // Open bus
	end

endmodule

`default_nettype wire

/* src/mmc5_top.sv */
// MMC5 mapper top level with plain ports, connects the register file to the mapping blocks
`timescale 1ns/1ps
`default_nettype none

module mmc5_top #(
	parameter int exram_aw = 10
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        ce,            // CPU cycle
	input  logic                        ppu_ce,        // PPU cycle
	input  logic [15:0]                 prg_ain,
	input  logic                        prg_read,
	input  logic                        prg_write,
	input  logic [7:0]                  prg_din,
	input  logic [13:0]                 chr_ain,
	input  logic                        ppu_in_frame,
	input  logic                        ppu_sprite16,
	input  logic [8:0]                  ppu_cycle,
	input  logic [8:0]                  ppu_scanline,
	output logic [mmc5_pkg::prg_aw-1:0] prg_aout,
	output logic [7:0]                  prg_dout,
	output logic                        prg_allow,
	output logic [mmc5_pkg::chr_aw-1:0] chr_aout,
	output logic                        vram_a10,
	output logic                        vram_ce,
	output logic                        irq
);

	logic status_read;
	logic irq_pending;

	mmc5_cfg_if cfg ();

	mmc5_regs u_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.ce           (ce),
		.prg_write    (prg_write),
		.prg_ain      (prg_ain),
		.prg_din      (prg_din),
		.ppu_sprite16 (ppu_sprite16),
		.cfg          (cfg.regs)
	);

	mmc5_prg_map u_prg_map (
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.cfg       (cfg.prg),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow)
	);

	mmc5_chr_map u_chr_map (
		.chr_ain      (chr_ain),
		.ppu_in_frame (ppu_in_frame),
		.ppu_sprite16 (ppu_sprite16),
		.ppu_cycle    (ppu_cycle),
		.cfg          (cfg.chr),
		.chr_aout     (chr_aout),
		.vram_a10     (vram_a10),
		.vram_ce      (vram_ce)
	);

	mmc5_scanline_irq u_irq (
		.clk          (clk),
		.rst_n        (rst_n),
		.ce           (ce),
		.ppu_ce       (ppu_ce),
		.ppu_in_frame (ppu_in_frame),
		.ppu_scanline (ppu_scanline),
		.status_read  (status_read),
		.cfg          (cfg.irq),
		.irq_pending  (irq_pending),
		.irq          (irq)
	);

	mmc5_cpu_port #(
		.exram_aw (exram_aw)
	) u_cpu_port (
		.clk          (clk),
		.ce           (ce),
		.prg_read     (prg_read),
		.prg_write    (prg_write),
		.prg_ain      (prg_ain),
		.prg_din      (prg_din),
		.ppu_in_frame (ppu_in_frame),
		.irq_pending  (irq_pending),
		.cfg          (cfg.cpu),
		.status_read  (status_read),
		.prg_dout     (prg_dout)
	);

endmodule

`default_nettype wire

/* tb/mmc5_props.sv */
// Concurrent assertions on the mapper outputs, attached to mmc5_top by the bind below
`timescale 1ns/1ps
`default_nettype none

module mmc5_props (
	input logic        clk,
	input logic        rst_n,
	input logic        irq,
	input logic [15:0] prg_ain,
	input logic        prg_allow,
	input logic [13:0] chr_ain,
	input logic        vram_ce
);

	// Reset clears the pending flag and the enable
	irq_low_in_reset: assert property (@(posedge clk) !rst_n |=> !irq)
		else $error("irq high after a reset cycle");

	// Register and ExRAM windows stay off the cartridge bus
	allow_low_below_6000: assert property (@(posedge clk) (prg_ain < 16'h6000) |-> !prg_allow)
		else $error("prg_allow high below $6000");

	vram_ce_needs_a13: assert property (@(posedge clk) vram_ce |-> chr_ain[13])
		else $error("vram_ce high outside the nametable space");

endmodule

bind mmc5_top mmc5_props props0 (
	.clk       (clk),
	.rst_n     (rst_n),
	.irq       (irq),
	.prg_ain   (prg_ain),
	.prg_allow (prg_allow),
	.chr_ain   (chr_ain),
	.vram_ce   (vram_ce)
);

`default_nettype wire

/* tb/mmc5_tb.sv */
// Directed testbench for the MMC5 mapper, built and run through build.f and the Makefile
`timescale 1ns/1ps
`default_nettype none

module mmc5_tb;

	localparam int test_cycles = 600;                 // Rough cycle count of all tests
	localparam int timeout_ns  = test_cycles * 100 * 2; // Double margin

	logic        clk;
	logic        rst_n;
	logic        ce;
	logic        ppu_ce;
	logic [15:0] prg_ain;
	logic        prg_read;
	logic        prg_write;
	logic [7:0]  prg_din;
	logic [13:0] chr_ain;
	logic        ppu_in_frame;
	logic        ppu_sprite16;
	logic [8:0]  ppu_cycle;
	logic [8:0]  ppu_scanline;
	logic [21:0] prg_aout;
	logic [7:0]  prg_dout;
	logic        prg_allow;
	logic [21:0] chr_aout;
	logic        vram_a10;
	logic        vram_ce;
	logic        irq;

	int err_count;
	int check_count;

	// Copies of the banks written by the tests
	logic [7:0] pb0;
	logic [7:0] pb1;
	logic [7:0] pb2;
	logic [6:0] pb3;
	logic [2:0] ram_bank_m;
	logic [9:0] cb [12];

	mmc5_top #(.exram_aw(10)) dut0 (.*);

	initial clk = 1'b0;
	always #50 clk = ~clk;  // 100 ns period

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		if (exp !== act) begin
			err_count++;
			$display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
		end
	endtask

	// PRG address from mode and slot, per the MMC5 banking table
	function automatic logic [21:0] prg_expect(input logic [1:0] mode, input logic [15:0] a);
		logic [7:0] sel;
		if (!a[15])
			sel = {5'b00000, ram_bank_m};  // $6000 always RAM
		else begin
			case (mode)
				2'd0: sel = {1'b1, pb3[6:2], a[14:13]};
				2'd1: sel = a[14] ? {1'b1, pb3[6:1], a[13]} : {pb1[7:1], a[13]};
				2'd2: begin
					if (!a[14])
						sel = {pb1[7:1], a[13]};
					else
						sel = a[13] ? {1'b1, pb3} : pb2;
				end
				default: begin
					case (a[14:13])
						2'd0:    sel = pb0;
						2'd1:    sel = pb1;
						2'd2:    sel = pb2;
						default: sel = {1'b1, pb3};
					endcase
				end
			endcase
		end
		if (sel[7])
			return {2'b00, sel[6:0], a[12:0]};
		return {6'h3C, sel[2:0], a[12:0]};
	endfunction

	// CHR address from mode and register set
	function automatic logic [21:0] chr_expect(input logic [1:0] mode, input logic set,
		input logic [13:0] a);
		logic [3:0] r;
		logic [9:0] b;
		logic [9:0] page;
		case (mode)
			2'd0:    r = set ? 4'd11 : 4'd7;
			2'd1:    r = set ? 4'd11 : (a[12] ? 4'd7 : 4'd3);
			2'd2:    r = set ? (a[11] ? 4'd11 : 4'd9) : {1'b0, a[12:11], 1'b1};
			default: r = set ? 4'd8 + {2'b00, a[11:10]} : {1'b0, a[12:10]};
		endcase
		b = cb[r];
		case (mode)
			2'd0:    page = {b[6:0], a[12:10]};  // 8 kB slice
			2'd1:    page = {b[7:0], a[11:10]};
			2'd2:    page = {b[8:0], a[10]};
			default: page = b;
		endcase
		return {2'b10, page, a[9:0]};
	endfunction

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		prg_ain   <= addr;
		prg_din   <= data;
		prg_write <= 1'b1;
		prg_read  <= 1'b0;
		@(posedge clk);  // Register takes it here
		prg_write <= 1'b0;
	endtask

	// Late reads wait one more edge for registered ExRAM data
	task automatic cpu_read(input logic [15:0] addr, input bit late, output logic [7:0] data);
		@(posedge clk);
		prg_ain   <= addr;
		prg_write <= 1'b0;
		prg_read  <= 1'b1;
		if (late)
			@(posedge clk);
		@(negedge clk);
		data = prg_dout;
		@(posedge clk);
		prg_read <= 1'b0;
	endtask

	task automatic prg_probe(input logic [15:0] addr, input logic wr);
		@(posedge clk);
		prg_ain   <= addr;
		prg_write <= wr;
		prg_read  <= !wr;
		@(negedge clk);
	endtask

	task automatic chr_probe(input logic [13:0] addr);
		@(posedge clk);
		chr_ain <= addr;
		@(negedge clk);
	endtask

	task automatic step_line(input logic [8:0] line);
		@(posedge clk);
		ppu_scanline <= line;
		ppu_ce       <= 1'b1;
		@(posedge clk);
		ppu_ce <= 1'b0;
		@(negedge clk);
	endtask

	task automatic wait_irq(input int max_cycles);
		int n;
		n = 0;
		while (!irq && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
		if (!irq) begin
			err_count++;
			$display("irq did not rise within %0d cycles of the compare line", max_cycles);
		end
	endtask

	task automatic test_prg();
		logic [15:0] a;
		logic [7:0]  d;
		prg_probe(16'hE000, 1'b0);
		compare("prg_aout", 32'h000F_E000, 32'(prg_aout));  // Reset bank $7F
		ram_bank_m = 3'($urandom);
		pb0 = 8'($urandom);
		pb1 = 8'($urandom);
		pb2 = 8'($urandom);
		d   = 8'($urandom);
		pb3 = d[6:0];
		cpu_write(16'h5113, {5'b00000, ram_bank_m});
		cpu_write(16'h5114, pb0);
		cpu_write(16'h5115, pb1);
		cpu_write(16'h5116, pb2);
		cpu_write(16'h5117, d);
		for (int m = 0; m < 4; m++) begin
			cpu_write(16'h5100, 8'(m));
			for (int s = 3; s < 8; s++) begin  // $6000 up to $E000
				a = {3'(s), 13'($urandom)};
				prg_probe(a, 1'b0);
				compare("prg_aout", 32'(prg_expect(2'(m), a)), 32'(prg_aout));
			end
		end
	endtask

	task automatic test_protect();
		cpu_write(16'h5100, 8'd3);
		cpu_write(16'h5114, 8'h80 | 8'($urandom));  // ROM at $8000
		cpu_write(16'h5115, 8'h7F & 8'($urandom));  // RAM at $A000
		prg_probe(16'h6000, 1'b1);
		compare("prg_allow", 32'd0, 32'(prg_allow));
		cpu_write(16'h5102, 8'h02);
		prg_probe(16'h6000, 1'b1);
		compare("prg_allow", 32'd0, 32'(prg_allow));  // One key only
		cpu_write(16'h5103, 8'h01);
		prg_probe(16'h6000, 1'b1);
		compare("prg_allow", 32'd1, 32'(prg_allow));
		prg_probe(16'hA123, 1'b1);
		compare("prg_allow", 32'd1, 32'(prg_allow));
		prg_probe(16'h8000, 1'b1);
		compare("prg_allow", 32'd0, 32'(prg_allow));  // ROM never writable
		prg_probe(16'h9000, 1'b0);
		compare("prg_allow", 32'd1, 32'(prg_allow));
		cpu_write(16'h5103, 8'h02);                   // Wrong key locks again
		prg_probe(16'h6000, 1'b1);
		compare("prg_allow", 32'd0, 32'(prg_allow));
		prg_probe(16'h6000, 1'b0);
		compare("prg_allow", 32'd1, 32'(prg_allow));
	endtask

	task automatic test_chr();
		logic [1:0]  upper;
		logic [7:0]  d;
		logic [7:0]  mir;
		logic [1:0]  bits;
		logic [13:0] a;
		upper = 2'($urandom);
		cpu_write(16'h5130, {6'b000000, upper});
		for (int m = 0; m < 4; m++) begin
			cpu_write(16'h5101, 8'(m));
			for (int r = 0; r < 12; r++) begin
				d = 8'($urandom);
				cpu_write(16'h5120 + 16'(r), d);
				cb[r] = {upper, d};
			end
			// Last write was $512B, but 8x8 sprites keep set 0
			for (int k = 0; k < 8; k++) begin
				a = {1'b0, 3'(k), 10'($urandom)};
				chr_probe(a);
				compare("chr_aout", 32'(chr_expect(2'(m), 1'b0, a)), 32'(chr_aout));
			end
		end
		@(posedge clk);
		ppu_sprite16 <= 1'b1;  // Out of frame, set follows the last write
		d = 8'($urandom);
		cpu_write(16'h5129, d);
		cb[9] = {upper, d};
		a = {4'b0001, 10'($urandom)};  // Slot 1 of the background set
		chr_probe(a);
		compare("chr_aout", 32'(chr_expect(2'd3, 1'b1, a)), 32'(chr_aout));
		cpu_write(16'h5121, ~d);       // Sprite slot 1 differs from background slot 1
		cb[1] = {upper, ~d};
		chr_probe(a);
		compare("chr_aout", 32'(chr_expect(2'd3, 1'b0, a)), 32'(chr_aout));
		cpu_write(16'h512A, d);
		cb[10] = {upper, d};
		@(posedge clk);
		ppu_sprite16 <= 1'b0;  // Falling edge returns to set 0
		a = {4'b0110, 10'($urandom)};
		chr_probe(a);
		compare("chr_aout", 32'(chr_expect(2'd3, 1'b0, a)), 32'(chr_aout));

		mir = 8'($urandom);
		cpu_write(16'h5105, mir);
		for (int nt = 0; nt < 4; nt++) begin
			a = {2'b10, 2'(nt), 10'($urandom)};
			chr_probe(a);
			bits = 2'(mir >> (2 * nt));
			compare("vram_a10", 32'(bits[0]), 32'(vram_a10));
			compare("vram_ce", 32'(!bits[1]), 32'(vram_ce));
		end
		chr_probe({2'b00, 12'($urandom)});
		compare("vram_ce", 32'd0, 32'(vram_ce));  // Pattern fetch stays on the cartridge
	endtask

	task automatic test_exram();
		logic [15:0] ea;
		logic [7:0]  d;
		logic [7:0]  q;
		ea = {6'h17, 10'($urandom)};
		d  = 8'($urandom) | 8'h01;  // Nonzero, so a zero write shows
		cpu_write(16'h5104, 8'd2);
		cpu_write(ea, d);
		cpu_read(ea, 1'b1, q);
		compare("prg_dout", 32'(d), 32'(q));
		cpu_write(16'h5104, 8'd3);  // Read only
		cpu_write(ea, ~d);
		cpu_read(ea, 1'b1, q);
		compare("prg_dout", 32'(d), 32'(q));
		cpu_write(16'h5104, 8'd0);
		cpu_write(ea, d);           // Out of frame stores zero
		cpu_read(ea, 1'b0, q);
		compare("prg_dout", 32'h0000_00FF, 32'(q));  // Not readable in mode 0
		cpu_write(16'h5104, 8'd2);
		cpu_read(ea, 1'b1, q);
		compare("prg_dout", 32'd0, 32'(q));
	endtask

	task automatic test_mult();
		logic [7:0]  x;
		logic [7:0]  y;
		logic [15:0] p;
		logic [7:0]  q;
		for (int i = 0; i < 4; i++) begin
			x = 8'($urandom);
			y = 8'($urandom);
			p = {8'h00, x} * {8'h00, y};
			cpu_write(16'h5205, x);
			cpu_write(16'h5206, y);
			cpu_read(16'h5205, 1'b0, q);
			compare("prg_dout", 32'(p[7:0]), 32'(q));
			cpu_read(16'h5206, 1'b0, q);
			compare("prg_dout", 32'(p[15:8]), 32'(q));
		end
	endtask

	task automatic test_irq();
		int         n;
		logic [7:0] q;
		n = 1 + int'($urandom % 20);
		@(posedge clk);
		ppu_in_frame <= 1'b1;
		cpu_write(16'h5203, 8'(n));
		cpu_write(16'h5204, 8'h80);  // irq_enable
		for (int l = 0; l < n; l++) begin
			step_line(9'(l));
			compare("irq", 32'd0, 32'(irq));
		end
		step_line(9'(n));
		wait_irq(8);
		compare("irq", 32'd1, 32'(irq));
		cpu_read(16'h5204, 1'b0, q);
		compare("prg_dout", 32'h0000_00FF, 32'(q));  // Pending and in frame
		cpu_read(16'h5204, 1'b0, q);
		compare("prg_dout", 32'h0000_007F, 32'(q));  // Cleared by the first read
		@(negedge clk);
		compare("irq", 32'd0, 32'(irq));

		cpu_write(16'h5203, 8'd0);  // Zero never fires
		for (int l = 3; l >= 0; l--) begin
			step_line(9'(l));
			compare("irq", 32'd0, 32'(irq));
		end
		cpu_write(16'h5203, 8'd240);
		for (int l = 236; l < 244; l++) begin
			step_line(9'(l));
			compare("irq", 32'd0, 32'(irq));
		end

		cpu_write(16'h5203, 8'd5);
		step_line(9'd4);
		step_line(9'd5);
		wait_irq(8);
		@(posedge clk);
		ppu_in_frame <= 1'b0;  // Leaving the frame clears it
		@(posedge clk);
		@(negedge clk);
		compare("irq", 32'd0, 32'(irq));
	endtask

	initial begin
		void'($urandom(89));
		err_count    = 0;
		check_count  = 0;
		rst_n        = 1'b0;
		ce           = 1'b1;  // Every clock is a CPU cycle
		ppu_ce       = 1'b0;
		prg_ain      = '0;
		prg_read     = 1'b0;
		prg_write    = 1'b0;
		prg_din      = '0;
		chr_ain      = '0;
		ppu_in_frame = 1'b0;
		ppu_sprite16 = 1'b0;
		ppu_cycle    = '0;
		ppu_scanline = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		test_prg();
		test_protect();
		test_chr();
		test_exram();
		test_mult();
		test_irq();
		$display("Checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#(timeout_ns);
		$display("Timeout: tests did not finish within %0d ns", timeout_ns);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
src/mmc5_pkg.sv
src/mmc5_cfg_if.sv
src/mmc5_regs.sv
src/mmc5_prg_map.sv
src/mmc5_chr_map.sv
src/mmc5_scanline_irq.sv
src/mmc5_cpu_port.sv
src/mmc5_top.sv
tb/mmc5_props.sv
tb/mmc5_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module mmc5_tb -Mdir obj_dir -f build.f
	./obj_dir/Vmmc5_tb > sim.log 2>&1; cat sim.log
	! grep -q "Simulation failed" sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
